// ==== fpu_s.f ====
+incdir+bench
verilog/fpu_pkg.sv
verilog/fpu_ctrl.sv
verilog/fp_special.sv
verilog/fp_align.sv
verilog/fp_add_norm.sv
verilog/fp_round.sv
verilog/fpu_s.sv
bench/fpu_s_tb.sv

// ==== Makefile ====
# Verilator flow for the single-precision FPU
SIM      := verilator
TOP      := fpu_s_tb
FILELIST := fpu_s.f
FLAGS    := --timing --timescale 1ns/1ps
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/fpu_model.svh ====
// ==============================
// FPU reference model
// Exact integer add/sub with IEEE rounding, min/max order
// ==============================
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

function automatic bit is_nan(input logic [31:0] x);
  return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
endfunction

function automatic bit is_snan(input logic [31:0] x);
  return is_nan(x) && !x[22]; // Quiet bit clear
endfunction

function automatic bit is_inf(input logic [31:0] x);
  return (x[30:23] == 8'hFF) && (x[22:0] == 23'd0);
endfunction

// Decided without the add pipeline
function automatic bit add_is_special(input logic [31:0] a, input logic [31:0] b);
  return is_nan(a) || is_nan(b) || is_inf(a) || is_inf(b) ||
         ((a[30:23] == 8'd0) && (b[30:23] == 8'd0));
endfunction

// Monotonic key, -0 sorts below +0
function automatic logic [31:0] order_key(input logic [31:0] x);
  return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

// Returns {flags, value}, b already carries its effective sign
function automatic logic [36:0] model_addsub(input logic [31:0] a, input logic [31:0] b,
                                             input logic [2:0] rm);
  logic [127:0] va, vb, mag, kept, rem, half;
  logic [7:0]   ea, eb, emin;
  logic         sa, sb, sr, up, nx;
  int           msb, sh, er;
  sa = a[31];
  sb = b[31];
  ea = a[30:23];
  eb = b[30:23];
  if (is_nan(a) || is_nan(b) || (is_inf(a) && is_inf(b) && (sa != sb)))
    return {5'b10000, QNAN};
  if (is_inf(a))
    return {5'd0, a};
  if (is_inf(b))
    return {5'd0, b};
  if ((ea == 8'd0) && (eb == 8'd0)) // Both flushed
    return {5'd0, (sa & sb) | ((sa ^ sb) & (rm == RM_RDN)), 31'd0};
  emin = (ea == 8'd0) ? eb : (eb == 8'd0) ? ea : ((ea < eb) ? ea : eb);
  va = (ea == 8'd0) ? 128'd0 : ({104'd0, 1'b1, a[22:0]} << (ea - emin));
  vb = (eb == 8'd0) ? 128'd0 : ({104'd0, 1'b1, b[22:0]} << (eb - emin));
  if (sa == sb) begin
    mag = va + vb;
    sr  = sa;
  end else if (va >= vb) begin
    mag = va - vb;
    sr  = sa;
  end else begin
    mag = vb - va;
    sr  = sb;
  end
  if (mag == 128'd0)
    return {5'd0, rm == RM_RDN, 31'd0}; // Exact cancellation
  msb = 0;
  for (int i = 0; i < 128; i++)
    if (mag[i]) msb = i;
  sh = msb - 23;
  er = int'(emin) + sh;
  if (sh > 0) begin
    kept = mag >> sh;
    rem  = mag & ((128'd1 << sh) - 128'd1);
    half = 128'd1 << (sh - 1);
  end else begin
    kept = mag << (-sh);
    rem  = 128'd0;
    half = 128'd1;
  end
  nx = (rem != 128'd0);
  case (rm)
    RM_RNE:  up = (rem > half) || ((rem == half) && kept[0]);
    RM_RMM:  up = (rem >= half);
    RM_RDN:  up = nx && sr;
    RM_RUP:  up = nx && !sr;
    default: up = 1'b0;
  endcase
  kept = kept + 128'(up);
  if (kept[24]) begin // Rounding carried into a new bit
    kept = kept >> 1;
    er   = er + 1;
  end
  if (er > 254) begin
    if ((rm == RM_RNE) || (rm == RM_RMM) || ((rm == RM_RUP) && !sr) || ((rm == RM_RDN) && sr))
      return {5'b00101, sr, 8'hFF, 23'd0};
    return {5'b00101, sr, 8'hFE, 23'h7F_FFFF};
  end
  if (er < 1)
    return {5'b00011, sr, 31'd0};
  return {4'b0000, nx, sr, er[7:0], kept[22:0]};
endfunction

function automatic logic [36:0] model_minmax(input logic [5:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
  logic [31:0] r;
  if (is_nan(a) && is_nan(b))
    r = QNAN;
  else if (is_nan(a))
    r = b;
  else if (is_nan(b))
    r = a;
  else if ((order_key(a) < order_key(b)) == (op == OP_FMIN))
    r = a;
  else
    r = b;
  return {is_snan(a) || is_snan(b), 4'd0, r};
endfunction

`endif

// ==== bench/fpu_s_tb.sv ====
// ==============================
// FPU testbench
// Directed and LCG tests against the reference model
// ==============================
`timescale 1ns/1ps

module fpu_s_tb;
  import fpu_pkg::*;
  `include "fpu_model.svh"

  localparam int TIMEOUT = 20; // Cycles to wait for done_o

  logic        clk, rst_i, start_i, busy_o, done_o;
  logic [31:0] rs1_i, rs2_i, rs3_i, c_o;
  logic [5:0]  alu_op_i;
  logic [2:0]  frm_i;
  logic [4:0]  fflags_o;
  logic [31:0] seed = 32'he7d0c6c1;

  fpu_s u_dut (
    .clk (clk), .rst_i (rst_i), .rs1_i (rs1_i), .rs2_i (rs2_i), .rs3_i (rs3_i),
    .alu_op_i (alu_op_i), .frm_i (frm_i), .start_i (start_i),
    .c_o (c_o), .fflags_o (fflags_o), .busy_o (busy_o), .done_o (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] random_float(input logic [7:0] e);
    logic [31:0] r;
    r = lcg_next();
    return {r[31], e, r[22:0]}; // Random sign and fraction
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
  endtask

  // Starts one op and checks busy_o and latency up to done_o
  task automatic run_op(input logic [5:0] op, input logic [31:0] a, input logic [31:0] b,
                        input logic [2:0] rm, input int exp_lat, input bit poke,
                        output logic [31:0] res, output logic [4:0] flg);
    int lat;
    lat = 0;
    @(posedge clk);
    #2;
    rs1_i    = a;
    rs2_i    = b;
    rs3_i    = lcg_next(); // Must not matter
    alu_op_i = op;
    frm_i    = rm;
    start_i  = 1'b1;
    @(posedge clk);
    #2;
    if (poke) begin // Second start while busy
      rs1_i = lcg_next();
      rs2_i = lcg_next();
    end
    start_i = poke;
    while (!done_o) begin
      check_eq("busy_o", 32'(busy_o), 32'd1);
      if (lat == TIMEOUT)
        abort_run("Timeout: done_o did not rise after start_i");
      @(posedge clk);
      #2;
      start_i = 1'b0;
      lat++;
    end
    check_eq("latency", lat, exp_lat);
    check_eq("busy_o", 32'(busy_o), 32'd0); // Low in the done cycle
    res = c_o;
    flg = fflags_o;
  endtask

  task automatic check_op(input logic [5:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic [2:0] rm, input bit poke);
    logic [31:0] b_eff, res;
    logic [36:0] exp_v;
    logic [4:0]  flg;
    int          lat;
    b_eff = {b[31] ^ (op == OP_FSUB), b[30:0]};
    if ((op == OP_FMIN) || (op == OP_FMAX)) begin
      exp_v = model_minmax(op, a, b);
      lat   = 1;
    end else begin
      exp_v = model_addsub(a, b_eff, rm);
      lat   = add_is_special(a, b_eff) ? 1 : 3;
    end
    run_op(op, a, b, rm, lat, poke, res, flg);
    check_eq("c_o", res, exp_v[31:0]);
    check_eq("fflags_o", 32'(flg), 32'(exp_v[36:32]));
  endtask

  task automatic reset_outputs();
    check_eq("busy_o", 32'(busy_o), 32'd0);
    check_eq("done_o", 32'(done_o), 32'd0);
    check_eq("c_o", c_o, 32'd0);
    check_eq("fflags_o", 32'(fflags_o), 32'd0);
  endtask

  task automatic directed_add();
    check_op(OP_FSUB, 32'h3F80_0000, 32'h3F80_0000, RM_RNE, 1'b0); // x - x is +0
    check_op(OP_FSUB, 32'h3F80_0000, 32'h3F80_0000, RM_RDN, 1'b0); // RDN gives -0
    check_op(OP_FADD, 32'h3FC0_0000, 32'h3FC0_0000, RM_RNE, 1'b0); // Carry out
    check_op(OP_FSUB, 32'h3F80_0001, 32'h3F80_0000, RM_RNE, 1'b0); // Deep cancellation
    check_op(OP_FADD, 32'h3F80_0000, 32'h2680_0000, RM_RNE, 1'b0); // Gap of 50
    check_op(OP_FADD, 32'h3F80_0000, 32'h2680_0000, RM_RUP, 1'b0);
    check_op(OP_FADD, 32'h3F80_0000, 32'h3380_0000, RM_RNE, 1'b0); // Tie to even
    check_op(OP_FADD, 32'h3F80_0000, 32'h3380_0000, RM_RMM, 1'b0); // Tie away
  endtask

  task automatic random_add();
    int ea, eb;
    for (int i = 0; i < 200; i++) begin
      ea = 64 + int'(lcg_next() % 127);
      eb = ea + int'(lcg_next() % 81) - 40; // Gap up to 40
      if (eb < 64)
        eb = 64;
      if (eb > 190)
        eb = 190;
      check_op(lcg_next() % 2 == 0 ? OP_FADD : OP_FSUB, random_float(8'(ea)),
               random_float(8'(eb)), 3'(i % 5), 1'b0);
    end
  endtask

  task automatic special_operands();
    check_op(OP_FADD, QNAN, 32'h3F80_0000, RM_RNE, 1'b0);
    check_op(OP_FADD, 32'h3F80_0000, 32'h7F80_0001, RM_RNE, 1'b0);         // Signaling NaN
    check_op(OP_FADD, 32'h7F80_0000, 32'hFF80_0000, RM_RNE, 1'b0);         // Inf - Inf
    check_op(OP_FSUB, 32'h7F80_0000, 32'h7F80_0000, RM_RNE, 1'b0);
    check_op(OP_FADD, 32'h7F80_0000, 32'h3F80_0000, RM_RNE, 1'b0);
    check_op(OP_FSUB, 32'h3F80_0000, 32'h7F80_0000, RM_RNE, 1'b0);         // Sign flipped
    check_op(OP_FADD, 32'h0000_0001, 32'h8000_0002, RM_RNE, 1'b0);         // Flushed pair
    check_op(OP_FADD, 32'h0000_0001, 32'h8000_0002, RM_RDN, 1'b0);
    check_op(OP_FADD, 32'h0040_0000, 32'h3F80_0000, RM_RNE, 1'b0);         // One subnormal
    check_op(OP_FSUB, 32'h0080_0001, 32'h0080_0000, RM_RNE, 1'b0);         // Tiny result
    check_op(OP_FSUB, 32'h8080_0001, 32'h8080_0000, RM_RDN, 1'b0);
    for (int m = 0; m < 5; m++) begin
      check_op(OP_FADD, 32'h7F7F_FFFF, 32'h7F7F_FFFF, 3'(m), 1'b0);        // Overflow
      check_op(OP_FADD, 32'hFF7F_FFFF, 32'hFF7F_FFFF, 3'(m), 1'b0);
    end
  endtask

  task automatic min_max_order();
    check_op(OP_FMIN, 32'h0000_0000, 32'h8000_0000, RM_RNE, 1'b0);
    check_op(OP_FMAX, 32'h0000_0000, 32'h8000_0000, RM_RNE, 1'b0);
    check_op(OP_FMAX, 32'h0000_0000, 32'h8000_0000, RM_RDN, 1'b0); // Mode leaves +0 alone
    check_op(OP_FMIN, 32'h8000_0000, 32'h0000_0000, RM_RNE, 1'b0);
    check_op(OP_FMIN, QNAN, 32'h4000_0000, RM_RNE, 1'b0);
    check_op(OP_FMAX, 32'h3F80_0000, 32'h7FA0_0000, RM_RNE, 1'b0);         // sNaN sets NV
    check_op(OP_FMIN, QNAN, 32'h7FA0_0000, RM_RNE, 1'b0);
    for (int i = 0; i < 20; i++)
      check_op(i % 2 ? OP_FMAX : OP_FMIN, random_float(8'(1 + lcg_next() % 254)),
               random_float(8'(1 + lcg_next() % 254)), 3'(i % 5), 1'b0);
  endtask

  task automatic busy_start_ignored();
    logic [31:0] res;
    check_op(OP_FADD, 32'h3FC0_0000, 32'h4020_0000, RM_RNE, 1'b1);
    check_op(OP_FMAX, 32'h3FC0_0000, 32'hC020_0000, RM_RNE, 1'b1);
    res = c_o;
    repeat (5) begin // No stray done from the ignored start
      @(posedge clk);
      #2;
      check_eq("done_o", 32'(done_o), 32'd0);
      check_eq("c_o", c_o, res);
    end
  endtask

  initial begin
    rst_i    = 1'b1;
    start_i  = 1'b0;
    rs1_i    = 32'd0;
    rs2_i    = 32'd0;
    rs3_i    = 32'd0;
    alu_op_i = OP_FADD;
    frm_i    = RM_RNE;
    repeat (3) @(posedge clk);
    #2;
    rst_i = 1'b0;
    reset_outputs();
    directed_add();
    random_add();
    special_operands();
    min_max_order();
    busy_start_ignored();
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== verilog/fpu_s.sv ====
// ==============================
// Single-precision FPU, multi-cycle
// FADD/FSUB/FMIN/FMAX with a control sequencer and
// three add/sub datapath stages
// ==============================
`timescale 1ns/1ps

module fpu_s (
  input  logic        clk,
  input  logic        rst_i,
  input  logic [31:0] rs1_i,
  input  logic [31:0] rs2_i,
  input  logic [31:0] rs3_i,    // Reserved for fused ops
  input  logic [5:0]  alu_op_i,
  input  logic [2:0]  frm_i,
  input  logic        start_i,
  output logic [31:0] c_o,
  output logic [4:0]  fflags_o, // nv dz of uf nx
  output logic        busy_o,
  output logic        done_o
);
  import fpu_pkg::*;

  float32_u    opa, opb;   // Captured operands
  logic [2:0]  frm_q;
  logic        st1_en, st2_en;
  special_t    spec;
  align_t      al;
  norm_t       nm;
  logic [31:0] rnd_val;
  fflags_t     rnd_flags;

  fpu_ctrl u_ctrl (
    .clk (clk), .rst_i (rst_i), .start_i (start_i),
    .rs1_i (rs1_i), .rs2_i (rs2_i), .alu_op_i (alu_op_i), .frm_i (frm_i),
    .special_i (spec), .round_val_i (rnd_val), .round_flags_i (rnd_flags),
    .opa_o (opa), .opb_o (opb), .op_o (), .frm_o (frm_q),
    .st1_en_o (st1_en), .st2_en_o (st2_en),
    .c_o (c_o), .fflags_o (fflags_o), .busy_o (busy_o), .done_o (done_o)
  );

  fp_special u_special (
    .rs1_i (rs1_i), .rs2_i (rs2_i), .sub_i (alu_op_i[0]), .op_i (alu_op_i),
    .special_o (spec)
  );

  fp_align u_align (
    .clk (clk), .rst_i (rst_i), .en_i (st1_en),
    .opa_i (opa), .opb_i (opb), .frm_i (frm_q), .align_o (al)
  );

  fp_add_norm u_add_norm (.clk (clk), .rst_i (rst_i), .en_i (st2_en), .align_i (al), .norm_o (nm));

  fp_round u_round (.norm_i (nm), .value_o (rnd_val), .flags_o (rnd_flags));

endmodule

// ==== verilog/fp_round.sv ====
// ==============================
// FADD/FSUB rounding and pack
// Applies the rounding mode, handles overflow and flush to
// zero, and builds the result word and flags
// ==============================
`timescale 1ns/1ps

module fp_round (
  input  fpu_pkg::norm_t   norm_i,
  output logic [31:0]      value_o,
  output fpu_pkg::fflags_t flags_o
);
  import fpu_pkg::*;

  logic              lsb, guard, rs; // rs is round OR sticky
  logic              inexact;
  logic              round_up;
  logic [24:0]       rnd;            // Rounded significand plus carry
  logic signed [9:0] exp_r;
  logic [22:0]       frac;
  logic              to_inf;         // Overflow goes to infinity

  assign lsb     = norm_i.mant[3];
  assign guard   = norm_i.mant[2];
  assign rs      = norm_i.mant[1] | norm_i.mant[0];
  assign inexact = guard | rs;

  always_comb begin
    case (norm_i.rm)
      RM_RNE:  round_up = guard & (rs | lsb);
      RM_RDN:  round_up = inexact & norm_i.sign;
      RM_RUP:  round_up = inexact & !norm_i.sign;
      RM_RMM:  round_up = guard;
      default: round_up = 1'b0; // RTZ truncates
    endcase
  end

  assign rnd   = {1'b0, norm_i.mant[26:3]} + {24'd0, round_up};
  assign exp_r = norm_i.exp + $signed({9'd0, rnd[24]}); // Renormalize on carry
  assign frac  = rnd[24] ? rnd[23:1] : rnd[22:0];

  assign to_inf = (norm_i.rm == RM_RNE) || (norm_i.rm == RM_RMM) ||
                  ((norm_i.rm == RM_RUP) && !norm_i.sign) ||
                  ((norm_i.rm == RM_RDN) && norm_i.sign);

  always_comb begin
    flags_o = '0;
    if (norm_i.zero) begin
      value_o = {norm_i.sign, 31'd0}; // Exact zero
    end else if (exp_r > 10'sd254) begin
      value_o    = to_inf ? {norm_i.sign, EXP_MAX, 23'd0}
                          : {norm_i.sign, 8'hFE, 23'h7F_FFFF}; // Largest finite
      flags_o.of = 1'b1;
      flags_o.nx = 1'b1;
    end else if (exp_r < 10'sd1) begin
      value_o    = {norm_i.sign, 31'd0}; // Flush to zero
      flags_o.uf = 1'b1;
      flags_o.nx = 1'b1;
    end else begin
      value_o    = {norm_i.sign, exp_r[7:0], frac};
      flags_o.nx = inexact;
    end
  end

endmodule

// ==== verilog/fp_add_norm.sv ====
// ==============================
// FADD/FSUB add and normalize
// Adds or subtracts aligned mantissas, then normalizes by
// carry shift or leading-zero count
// ==============================
`timescale 1ns/1ps

module fp_add_norm (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            en_i,
  input  fpu_pkg::align_t align_i,
  output fpu_pkg::norm_t  norm_o
);
  import fpu_pkg::*;

  logic [27:0] sum;   // Carry bit on top
  logic [4:0]  lzc;
  logic [26:0] shl;
  norm_t       nxt;

  // Leading zeros of a 27-bit word
  function automatic logic [4:0] count_lz(input logic [26:0] v);
    logic [4:0] n;
    logic       found;
    n     = 5'd0;
    found = 1'b0;
    for (int i = 26; i >= 0; i--) begin
      if (v[i])
        found = 1'b1;
      else if (!found)
        n = n + 5'd1;
    end
    return n;
  endfunction

  // Larger magnitude first, so a difference never goes negative
  assign sum = align_i.sub ? {1'b0, align_i.mant_l, 3'b000} - {1'b0, align_i.mant_s}
                           : {1'b0, align_i.mant_l, 3'b000} + {1'b0, align_i.mant_s};

  assign lzc = count_lz(sum[26:0]);
  assign shl = sum[26:0] << lzc;

  always_comb begin
    nxt.rm   = align_i.rm;
    nxt.sign = align_i.sign;
    nxt.zero = 1'b0;
    if (sum == 28'd0) begin
      nxt.zero = 1'b1;
      nxt.exp  = 10'sd0;
      nxt.mant = 27'd0;
      if (align_i.sub)
        nxt.sign = (align_i.rm == RM_RDN); // x - x is +0 except RDN
    end else if (sum[27]) begin
      nxt.mant = {sum[27:2], sum[1] | sum[0]}; // Keep sticky
      nxt.exp  = $signed({2'b00, align_i.exp}) + 10'sd1;
    end else begin
      nxt.mant = shl; // Cancellation
      nxt.exp  = $signed({2'b00, align_i.exp}) - $signed({5'd0, lzc});
    end
  end

  // Stage 2 register
  always_ff @(posedge clk) begin
    if (rst_i)
      norm_o <= '0;
    else if (en_i)
      norm_o <= nxt;
  end

endmodule

// ==== verilog/fp_align.sv ====
// ==============================
// FADD/FSUB align stage
// Orders operands by magnitude and shifts the smaller
// mantissa right, keeping guard, round and sticky
// ==============================
`timescale 1ns/1ps

module fp_align (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              en_i,
  input  fpu_pkg::float32_u opa_i,
  input  fpu_pkg::float32_u opb_i,
  input  logic [2:0]        frm_i,
  output fpu_pkg::align_t   align_o
);
  import fpu_pkg::*;

  logic [30:0] mag_a, mag_b; // Magnitudes, subnormal as zero
  logic        swap;
  float32_u    big;
  float32_u    sml;
  logic [23:0] m_big, m_sml;
  logic [7:0]  e_diff;
  logic [53:0] shift_w;      // Shifted value over lost bits
  align_t      nxt;

  assign mag_a = (opa_i.f.exp == 8'd0) ? 31'd0 : opa_i.bits[30:0];
  assign mag_b = (opb_i.f.exp == 8'd0) ? 31'd0 : opb_i.bits[30:0];
  assign swap  = mag_b > mag_a;

  assign big = swap ? opb_i : opa_i;
  assign sml = swap ? opa_i : opb_i;

  assign m_big = (big.f.exp == 8'd0) ? 24'd0 : {1'b1, big.f.man}; // Hidden bit
  assign m_sml = (sml.f.exp == 8'd0) ? 24'd0 : {1'b1, sml.f.man};

  assign e_diff  = big.f.exp - sml.f.exp; // Never negative
  assign shift_w = {m_sml, 3'b000, 27'd0} >> e_diff;

  always_comb begin
    nxt.sign   = big.f.sign;
    nxt.exp    = big.f.exp;
    nxt.mant_l = m_big;
    if (e_diff > 8'd26)
      nxt.mant_s = {26'd0, |m_sml}; // Whole mantissa into sticky
    else
      nxt.mant_s = {shift_w[53:28], shift_w[27] | (|shift_w[26:0])};
    nxt.sub = opa_i.f.sign ^ opb_i.f.sign; // Signs already effective
    nxt.rm  = frm_i;
  end

  // Stage 1 register
  always_ff @(posedge clk) begin
    if (rst_i)
      align_o <= '0;
    else if (en_i)
      align_o <= nxt;
  end

endmodule

// ==== verilog/fp_special.sv ====
// ==============================
// FPU special-case unit
// NaN, infinity and zero results for FADD/FSUB, and the full
// FMIN/FMAX result
// ==============================
`timescale 1ns/1ps

module fp_special (
  input  logic [31:0]       rs1_i,
  input  logic [31:0]       rs2_i,
  input  logic              sub_i,
  input  logic [5:0]        op_i,
  output fpu_pkg::special_t special_o
);
  import fpu_pkg::*;

  float32_u a;
  float32_u b;
  logic     is_addsub;
  logic     is_minmax;
  logic     b_sign;     // rs2 sign after FSUB flip
  logic     a_nan, b_nan;
  logic     a_snan, b_snan;
  logic     a_inf, b_inf;
  logic     a_zero, b_zero; // Zero or subnormal
  logic     a_lt_b;

  assign a.bits = rs1_i;
  assign b.bits = rs2_i;

  assign is_addsub = (op_i == OP_FADD) || (op_i == OP_FSUB);
  assign is_minmax = (op_i == OP_FMIN) || (op_i == OP_FMAX);
  assign b_sign    = b.f.sign ^ (sub_i & is_addsub);

  assign a_nan  = (a.f.exp == EXP_MAX) && (a.f.man != 23'd0);
  assign b_nan  = (b.f.exp == EXP_MAX) && (b.f.man != 23'd0);
  assign a_snan = a_nan && !a.f.man[22]; // Quiet bit clear
  assign b_snan = b_nan && !b.f.man[22];
  assign a_inf  = (a.f.exp == EXP_MAX) && (a.f.man == 23'd0);
  assign b_inf  = (b.f.exp == EXP_MAX) && (b.f.man == 23'd0);
  assign a_zero = (a.f.exp == 8'd0);   // Subnormals flushed
  assign b_zero = (b.f.exp == 8'd0);

  // Sign/magnitude order, -0 below +0
  always_comb begin
    if (a.f.sign != b.f.sign)
      a_lt_b = a.f.sign;
    else if (!a.f.sign)
      a_lt_b = a.bits[30:0] < b.bits[30:0];
    else
      a_lt_b = a.bits[30:0] > b.bits[30:0]; // Both negative
  end

  always_comb begin
    special_o = '0;
    if (is_addsub) begin
      if (a_nan || b_nan || (a_inf && b_inf && (a.f.sign != b_sign))) begin
        special_o.hit      = 1'b1;
        special_o.value    = QNAN;
        special_o.flags.nv = 1'b1;
      end else if (a_inf) begin
        special_o.hit   = 1'b1;
        special_o.value = a.bits;
      end else if (b_inf) begin
        special_o.hit   = 1'b1;
        special_o.value = {b_sign, b.bits[30:0]};
      end else if (a_zero && b_zero) begin
        special_o.hit   = 1'b1;
        special_o.value = {a.f.sign & b_sign, 31'd0}; // RDN mixed case fixed in ctrl
      end
    end else if (is_minmax) begin
      special_o.hit      = 1'b1; // Always decided here
      special_o.flags.nv = a_snan | b_snan;
      if (a_nan && b_nan)
        special_o.value = QNAN;
      else if (a_nan)
        special_o.value = b.bits; // Other operand wins
      else if (b_nan)
        special_o.value = a.bits;
      else
        special_o.value = (a_lt_b ^ (op_i == OP_FMAX)) ? a.bits : b.bits;
    end
  end

endmodule

// ==== verilog/fpu_ctrl.sv ====
// ==============================
// FPU control sequencer
// Captures operands on start, steps the add stages and loads
// the result from the special or the rounding path
// ==============================
`timescale 1ns/1ps

module fpu_ctrl (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               start_i,
  input  logic [31:0]        rs1_i,
  input  logic [31:0]        rs2_i,
  input  logic [5:0]         alu_op_i,
  input  logic [2:0]         frm_i,
  input  fpu_pkg::special_t  special_i,
  input  logic [31:0]        round_val_i,
  input  fpu_pkg::fflags_t   round_flags_i,
  output fpu_pkg::float32_u  opa_o,
  output fpu_pkg::float32_u  opb_o,
  output logic [5:0]         op_o,
  output logic [2:0]         frm_o,
  output logic               st1_en_o,
  output logic               st2_en_o,
  output logic [31:0]        c_o,
  output fpu_pkg::fflags_t   fflags_o,
  output logic               busy_o,
  output logic               done_o
);
  import fpu_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ALIGN, S_ADD, S_ROUND} state_t;

  state_t   state;
  special_t spec_q;    // Special result, taken with the operands
  logic     capture;
  logic     zero_rdn;  // Mixed-sign zero sum under RDN

  assign capture  = (state == S_IDLE) && start_i; // Start ignored while busy
  assign st1_en_o = (state == S_ALIGN) && !spec_q.hit;
  assign st2_en_o = (state == S_ADD);
  assign busy_o   = (state != S_IDLE);

  // Zero + zero of opposite sign gives -0 only when rounding down
  assign zero_rdn = ((op_o == OP_FADD) || (op_o == OP_FSUB)) && (frm_o == RM_RDN) &&
                    (spec_q.value[30:0] == 31'd0) && (opa_o.f.sign != opb_o.f.sign);

  always_ff @(posedge clk) begin
    if (capture) begin
      opa_o.bits <= rs1_i;
      opb_o.bits <= {rs2_i[31] ^ (alu_op_i == OP_FSUB), rs2_i[30:0]}; // Effective sign
      op_o       <= alu_op_i;
      frm_o      <= frm_i;
      spec_q     <= special_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state    <= S_IDLE;
      c_o      <= 32'd0;
      fflags_o <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0; // Single-cycle strobe
      case (state)
        S_IDLE:  if (start_i) state <= S_ALIGN;
        S_ALIGN: begin
          if (spec_q.hit) begin // Early finish
            c_o      <= {spec_q.value[31] | zero_rdn, spec_q.value[30:0]};
            fflags_o <= spec_q.flags;
            done_o   <= 1'b1;
            state    <= S_IDLE;
          end else begin
            state <= S_ADD;
          end
        end
        S_ADD:   state <= S_ROUND;
        S_ROUND: begin
          c_o      <= round_val_i;
          fflags_o <= round_flags_i;
          done_o   <= 1'b1;
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/fpu_pkg.sv ====
// ==============================
// FPU shared definitions
// Op codes, rounding modes, float word view, flags and the
// structs passed between the add/sub stages
// ==============================
package fpu_pkg;

  // Operation codes, FADD/FSUB differ only in bit 0
  localparam logic [5:0] OP_FADD = 6'h00;
  localparam logic [5:0] OP_FSUB = 6'h01;
  localparam logic [5:0] OP_FMIN = 6'h04;
  localparam logic [5:0] OP_FMAX = 6'h05;

  // RISC-V frm encodings
  localparam logic [2:0] RM_RNE = 3'd0; // Nearest, ties to even
  localparam logic [2:0] RM_RTZ = 3'd1; // Toward zero
  localparam logic [2:0] RM_RDN = 3'd2; // Toward -inf
  localparam logic [2:0] RM_RUP = 3'd3; // Toward +inf
  localparam logic [2:0] RM_RMM = 3'd4; // Nearest, ties away

  localparam logic [31:0] QNAN    = 32'h7FC0_0000; // Canonical quiet NaN
  localparam logic [7:0]  EXP_MAX = 8'hFF;         // Inf/NaN exponent

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
  } float_fields_t;

  // Same word seen raw or split into fields
  typedef union packed {
    logic [31:0]   bits;
    float_fields_t f;
  } float32_u;

  typedef struct packed {
    logic nv; // Invalid
    logic dz; // Divide by zero
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } fflags_t;

  typedef struct packed {
    logic        sign;   // Sign of the larger operand
    logic [7:0]  exp;    // Larger exponent
    logic [23:0] mant_l; // Larger mantissa, hidden bit included
    logic [26:0] mant_s; // Smaller mantissa shifted, plus G/R/S
    logic        sub;    // Effective subtract
    logic [2:0]  rm;
  } align_t;

  typedef struct packed {
    logic              sign;
    logic signed [9:0] exp;  // Room for carry and cancellation
    logic [26:0]       mant; // Hidden, 23 frac, G, R, S
    logic              zero; // Exact zero sum
    logic [2:0]        rm;
  } norm_t;

  typedef struct packed {
    logic        hit;   // Result fully decided here
    logic [31:0] value;
    fflags_t     flags;
  } special_t;

endpackage
